//--- src/cache_core_pkg.sv
package cache_core_pkg;

    ////////////////////
    // Core word geometry.

    localparam int WORD_BYTES = 4;
    localparam int WORD_BITS  = WORD_BYTES * 8;

    ////////////////////
    // Core opcodes.

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } core_op_e;

    ////////////////////
    // Core request and response.

    typedef struct packed {
        core_op_e              op;
        logic [31:0]           addr;   // Byte address.
        logic [WORD_BYTES-1:0] byteen; // Write lanes, ignored on reads.
        logic [WORD_BITS-1:0]  data;
    } core_req_t;

    typedef struct packed {
        logic [WORD_BITS-1:0] data;
    } core_rsp_t;

endpackage

//--- src/cache_mem_pkg.sv
package cache_mem_pkg;

    ////////////////////
    // Line geometry.

    localparam int LINE_BYTES       = 16;
    localparam int LINE_BITS        = LINE_BYTES * 8;
    localparam int LINE_OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int LINE_ADDR_BITS   = 32 - LINE_OFFSET_BITS;

    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // Byte enables cover the whole line.
    typedef struct packed {
        mem_op_e                   op;
        logic [LINE_ADDR_BITS-1:0] line_addr;
        logic [LINE_BYTES-1:0]     byteen;
        logic [LINE_BITS-1:0]      data;
    } mem_req_t;

    typedef struct packed {
        logic [LINE_BITS-1:0] data;
    } mem_rsp_t;

endpackage

//--- src/tag_access.sv
`timescale 1ns/1ps

module tag_access #(
    parameter int   LINES_PER_BANK = 64,
    localparam int  INDEX_BITS     = $clog2(LINES_PER_BANK),
    localparam int  TAG_BITS       = cache_mem_pkg::LINE_ADDR_BITS - INDEX_BITS
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [INDEX_BITS-1:0] line_index,
    input  logic [TAG_BITS-1:0]   tag_in,
    input  logic                  lookup_en,
    input  logic                  tag_fill,
    output logic                  hit
);

    logic [TAG_BITS-1:0]       tag_mem [LINES_PER_BANK];
    logic [LINES_PER_BANK-1:0] valid;
    logic [TAG_BITS-1:0]       tag_q;
    logic                      valid_q;

    ////////////////////
    // Storage.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else if (tag_fill) begin
            valid[line_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_fill) begin
            tag_mem[line_index] <= tag_in;
        end
    end

    ////////////////////
    // Lookup.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else if (lookup_en) begin
            valid_q <= valid[line_index];
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_en) begin
            tag_q <= tag_mem[line_index];
        end
    end

    // tag_in comes from the held request, so it lines up with tag_q.
    assign hit = valid_q && (tag_q == tag_in);

endmodule

//--- src/data_access.sv
`timescale 1ns/1ps

module data_access #(
    parameter int   LINES_PER_BANK = 64,
    localparam int  INDEX_BITS     = $clog2(LINES_PER_BANK),
    localparam int  LINE_BYTES     = cache_mem_pkg::LINE_BYTES,
    localparam int  LINE_BITS      = cache_mem_pkg::LINE_BITS
) (
    input  logic                  clk,
    input  logic [INDEX_BITS-1:0] line_index,
    input  logic                  data_we,
    input  logic                  data_fill,
    input  logic [LINE_BYTES-1:0] byteen,
    input  logic [LINE_BITS-1:0]  wdata,
    output logic [LINE_BITS-1:0]  rdata
);

    logic [LINE_BITS-1:0]  store [LINES_PER_BANK];
    logic [LINE_BYTES-1:0] wr_byteen;

    assign wr_byteen = data_fill ? '1 : byteen; // Fill replaces the whole line.

    // Single port, read every cycle.
    always_ff @(posedge clk) begin
        if (data_we) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                if (wr_byteen[i]) begin
                    store[line_index][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
        rdata <= store[line_index]; // Old data on a same-cycle write.
    end

endmodule

//--- src/word_lane.sv
`timescale 1ns/1ps

module word_lane #(
    localparam int LINE_BYTES = cache_mem_pkg::LINE_BYTES,
    localparam int LINE_BITS  = cache_mem_pkg::LINE_BITS,
    localparam int WORD_BYTES = cache_core_pkg::WORD_BYTES,
    localparam int WORD_BITS  = cache_core_pkg::WORD_BITS
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  cache_core_pkg::core_req_t req_q,
    input  logic [LINE_BITS-1:0]      store_line,
    input  logic [LINE_BITS-1:0]      fill_line,
    input  logic                      rsp_load,
    input  logic                      rsp_from_fill,
    output logic [LINE_BITS-1:0]      line_wdata,
    output logic [LINE_BYTES-1:0]     line_byteen,
    output cache_core_pkg::core_rsp_t core_rsp
);

    localparam int LANES     = LINE_BYTES / WORD_BYTES;
    localparam int LANE_BITS = $clog2(LANES);
    localparam int WORD_OFF  = $clog2(WORD_BYTES);

    logic [LANE_BITS-1:0]  lane;
    logic [LINE_BYTES-1:0] word_byteen;
    logic [WORD_BITS-1:0]  rsp_word;

    assign lane = req_q.addr[WORD_OFF +: LANE_BITS]; // Address bits 3:2.

    ////////////////////
    // Write path.

    // The word is copied into every lane; byteen picks the live one.
    assign line_wdata  = rsp_from_fill ? fill_line : {LANES{req_q.data}};
    assign word_byteen = {{(LINE_BYTES - WORD_BYTES){1'b0}}, req_q.byteen};
    assign line_byteen = word_byteen << (lane * WORD_BYTES);

    ////////////////////
    // Response path.

    assign rsp_word = rsp_from_fill ? fill_line[lane*WORD_BITS +: WORD_BITS]
                                    : store_line[lane*WORD_BITS +: WORD_BITS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            core_rsp <= '0;
        end else if (rsp_load) begin
            core_rsp.data <= rsp_word;
        end
    end

endmodule

//--- src/mem_port.sv
`timescale 1ns/1ps

module mem_port #(
    localparam int LINE_BYTES     = cache_mem_pkg::LINE_BYTES,
    localparam int LINE_BITS      = cache_mem_pkg::LINE_BITS,
    localparam int LINE_ADDR_BITS = cache_mem_pkg::LINE_ADDR_BITS
) (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        mem_issue,
    input  cache_mem_pkg::mem_op_e      mem_op,
    input  logic [LINE_ADDR_BITS-1:0]   line_addr,
    input  logic [LINE_BYTES-1:0]       line_byteen,
    input  logic [LINE_BITS-1:0]        line_wdata,
    output logic                        mem_req_valid,
    output cache_mem_pkg::mem_req_t     mem_req
);

    logic is_write;

    assign is_write = mem_op == cache_mem_pkg::MEM_WRITE;

    // One-cycle strobe per issue.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_req_valid <= 1'b0;
        end else begin
            mem_req_valid <= mem_issue;
        end
    end

    ////////////////////
    // Request payload.

    always_ff @(posedge clk) begin
        if (mem_issue) begin
            mem_req.op        <= mem_op;
            mem_req.line_addr <= line_addr;
            if (is_write) begin
                mem_req.byteen <= line_byteen;
                mem_req.data   <= line_wdata;
            end else begin
                mem_req.byteen <= '1; // Whole line read.
                mem_req.data   <= '0;
            end
        end
    end

endmodule

//--- src/bank_ctrl.sv
`timescale 1ns/1ps

module bank_ctrl #(
    parameter int  LINES_PER_BANK = 64,
    localparam int INDEX_BITS     = $clog2(LINES_PER_BANK)
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      core_req_valid,
    input  cache_core_pkg::core_req_t core_req,
    input  logic                      hit,
    input  logic                      mem_rsp_valid,
    output logic                      busy,
    output cache_core_pkg::core_req_t req_q,
    output logic [INDEX_BITS-1:0]     line_index,
    output logic                      lookup_en,
    output logic                      tag_fill,
    output logic                      data_we,
    output logic                      data_fill,
    output logic                      mem_issue,
    output cache_mem_pkg::mem_op_e    mem_op,
    output logic                      rsp_load,
    output logic                      rsp_from_fill,
    output logic                      core_rsp_valid
);

    localparam int OFF = cache_mem_pkg::LINE_OFFSET_BITS;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MEM_WAIT,
        RESPOND
    } state_e;

    state_e state;
    state_e state_next;
    logic   accept;
    logic   is_read;

    assign busy           = (state == LOOKUP) || (state == MEM_WAIT);
    assign core_rsp_valid = state == RESPOND;
    assign accept         = core_req_valid && !busy; // Also taken during RESPOND.
    assign is_read        = req_q.op == cache_core_pkg::OP_READ;

    // Stores are read at the accept edge with the incoming address.
    assign line_index = busy ? req_q.addr[OFF +: INDEX_BITS] : core_req.addr[OFF +: INDEX_BITS];
    assign lookup_en  = accept;

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= core_req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////
    // Sequencing.

    always_comb begin
        state_next    = state;
        tag_fill      = 1'b0;
        data_we       = 1'b0;
        data_fill     = 1'b0;
        mem_issue     = 1'b0;
        mem_op        = cache_mem_pkg::MEM_READ;
        rsp_load      = 1'b0;
        rsp_from_fill = 1'b0;
        case (state)
            IDLE, RESPOND: begin
                state_next = accept ? LOOKUP : IDLE;
            end
            LOOKUP: begin
                if (is_read && hit) begin
                    rsp_load   = 1'b1; // Word from the data store.
                    state_next = RESPOND;
                end else begin
                    // Read miss fetches the line and every write goes through.
                    mem_issue  = 1'b1;
                    mem_op     = is_read ? cache_mem_pkg::MEM_READ : cache_mem_pkg::MEM_WRITE;
                    data_we    = !is_read && hit; // No allocate on a write miss.
                    state_next = MEM_WAIT;
                end
            end
            MEM_WAIT: begin
                if (mem_rsp_valid) begin
                    state_next = RESPOND;
                    if (is_read) begin
                        tag_fill      = 1'b1;
                        data_we       = 1'b1;
                        data_fill     = 1'b1;
                        rsp_load      = 1'b1;
                        rsp_from_fill = 1'b1;
                    end
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

//--- src/cache_bank_top.sv
`timescale 1ns/1ps

module cache_bank_top #(
    parameter int LINES_PER_BANK = 64
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      core_req_valid,
    input  cache_core_pkg::core_req_t core_req,
    output logic                      busy,
    output logic                      core_rsp_valid,
    output cache_core_pkg::core_rsp_t core_rsp,
    output logic                      mem_req_valid,
    output cache_mem_pkg::mem_req_t   mem_req,
    input  logic                      mem_rsp_valid,
    input  cache_mem_pkg::mem_rsp_t   mem_rsp
);

    localparam int INDEX_BITS     = $clog2(LINES_PER_BANK);
    localparam int OFF            = cache_mem_pkg::LINE_OFFSET_BITS;
    localparam int LINE_ADDR_BITS = cache_mem_pkg::LINE_ADDR_BITS;
    localparam int TAG_BITS       = LINE_ADDR_BITS - INDEX_BITS;

    cache_core_pkg::core_req_t            req_q;
    logic [INDEX_BITS-1:0]                line_index;
    logic                                 hit;
    logic                                 lookup_en;
    logic                                 tag_fill;
    logic                                 data_we;
    logic                                 data_fill;
    logic                                 mem_issue;
    cache_mem_pkg::mem_op_e               mem_op;
    logic                                 rsp_load;
    logic                                 rsp_from_fill;
    logic [cache_mem_pkg::LINE_BITS-1:0]  store_line;
    logic [cache_mem_pkg::LINE_BITS-1:0]  line_wdata;
    logic [cache_mem_pkg::LINE_BYTES-1:0] line_byteen;

    ////////////////////
    // Control.

    bank_ctrl #(
        .LINES_PER_BANK (LINES_PER_BANK)
    ) u_ctrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .hit            (hit),
        .mem_rsp_valid  (mem_rsp_valid),
        .busy           (busy),
        .req_q          (req_q),
        .line_index     (line_index),
        .lookup_en      (lookup_en),
        .tag_fill       (tag_fill),
        .data_we        (data_we),
        .data_fill      (data_fill),
        .mem_issue      (mem_issue),
        .mem_op         (mem_op),
        .rsp_load       (rsp_load),
        .rsp_from_fill  (rsp_from_fill),
        .core_rsp_valid (core_rsp_valid)
    );

    ////////////////////
    // Datapath.

    tag_access #(
        .LINES_PER_BANK (LINES_PER_BANK)
    ) u_tags (
        .clk        (clk),
        .arst_n     (arst_n),
        .line_index (line_index),
        .tag_in     (req_q.addr[OFF + INDEX_BITS +: TAG_BITS]),
        .lookup_en  (lookup_en),
        .tag_fill   (tag_fill),
        .hit        (hit)
    );

    data_access #(
        .LINES_PER_BANK (LINES_PER_BANK)
    ) u_data (
        .clk        (clk),
        .line_index (line_index),
        .data_we    (data_we),
        .data_fill  (data_fill),
        .byteen     (line_byteen),
        .wdata      (line_wdata),
        .rdata      (store_line)
    );

    word_lane u_lane (
        .clk           (clk),
        .arst_n        (arst_n),
        .req_q         (req_q),
        .store_line    (store_line),
        .fill_line     (mem_rsp.data),
        .rsp_load      (rsp_load),
        .rsp_from_fill (rsp_from_fill),
        .line_wdata    (line_wdata),
        .line_byteen   (line_byteen),
        .core_rsp      (core_rsp)
    );

    mem_port u_mem (
        .clk           (clk),
        .arst_n        (arst_n),
        .mem_issue     (mem_issue),
        .mem_op        (mem_op),
        .line_addr     (req_q.addr[OFF +: LINE_ADDR_BITS]),
        .line_byteen   (line_byteen),
        .line_wdata    (line_wdata),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req)
    );

endmodule

//--- sim/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    mem_req_valid,
    input  cache_mem_pkg::mem_req_t mem_req,
    output logic                    mem_rsp_valid,
    output cache_mem_pkg::mem_rsp_t mem_rsp
);

    localparam int LB = cache_mem_pkg::LINE_BYTES;

    logic [cache_mem_pkg::LINE_BITS-1:0] backing [logic [27:0]]; // Lines written so far.
    logic [cache_mem_pkg::LINE_BITS-1:0] line;
    logic [31:0]                         rnd_state;
    int                                  wait_cnt;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Unwritten words read back a value made from their byte address.
    function automatic logic [31:0] pattern(input logic [31:0] addr);
        return (addr ^ 32'h5A5A_A5A5) * 32'h9E37_79B1;
    endfunction

    function automatic logic [cache_mem_pkg::LINE_BITS-1:0] read_line(input logic [27:0] la);
        logic [cache_mem_pkg::LINE_BITS-1:0] l;
        if (backing.exists(la)) return backing[la];
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = pattern({la, w[1:0], 2'b00});
        end
        return l;
    endfunction

    initial begin
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_rsp_valid <= 1'b0;
            wait_cnt      <= 0;
            rnd_state     = 32'd37;
        end else begin
            mem_rsp_valid <= 1'b0;
            if (mem_req_valid) begin
                rnd_state = xorshift(rnd_state);
                wait_cnt <= 1 + int'(rnd_state[2:0]); // 1 to 8 cycles.
                line = read_line(mem_req.line_addr);
                if (mem_req.op == cache_mem_pkg::MEM_WRITE) begin
                    for (int b = 0; b < LB; b++) begin
                        if (mem_req.byteen[b]) line[b*8 +: 8] = mem_req.data[b*8 +: 8];
                    end
                    backing[mem_req.line_addr] = line;
                end
                mem_rsp.data <= line;
            end else if (wait_cnt == 1) begin
                mem_rsp_valid <= 1'b1;
                wait_cnt      <= 0;
            end else if (wait_cnt > 1) begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

//--- sim/tb_cache_bank.sv
`timescale 1ns/1ps

module tb_cache_bank;

    localparam int LINES      = 64;
    localparam int INDEX_BITS = $clog2(LINES);
    localparam int TIMEOUT    = 100; // Cycles per wait.

    logic                      clk;
    logic                      arst_n;
    logic                      core_req_valid;
    cache_core_pkg::core_req_t core_req;
    logic                      busy;
    logic                      core_rsp_valid;
    cache_core_pkg::core_rsp_t core_rsp;
    logic                      mem_req_valid;
    cache_mem_pkg::mem_req_t   mem_req;
    logic                      mem_rsp_valid;
    cache_mem_pkg::mem_rsp_t   mem_rsp;

    logic [7:0]       shadow_mem [logic [31:0]]; // Bytes written so far.
    logic [27:0]      sh_line [LINES];
    logic [LINES-1:0] sh_valid;
    logic             pend;
    logic             pend_read;
    logic             pend_hit;
    logic [31:0]      pend_addr;
    int               pend_age;
    int               mem_cnt;
    logic [31:0]      exp_data;
    logic [15:0]      exp_be;
    logic [127:0]     exp_line;
    logic [127:0]     exp_mask;
    int               err_count;
    int               timeouts;
    logic [31:0]      rnd;

    cache_bank_top #(.LINES_PER_BANK(LINES)) DUT (.*);

    tb_mem_model mem_model (.*);

    always #20 clk = ~clk;

    ////////////////////
    // Shadow model.

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] pattern(input logic [31:0] addr);
        return (addr ^ 32'h5A5A_A5A5) * 32'h9E37_79B1;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] addr);
        logic [31:0] a;
        logic [31:0] w;
        a = {addr[31:2], 2'b00};
        w = pattern(a);
        for (int b = 0; b < 4; b++) begin
            if (shadow_mem.exists(a + b)) w[b*8 +: 8] = shadow_mem[a + b];
        end
        return w;
    endfunction

    always @(posedge clk or negedge arst_n) begin
        logic [31:0]  a;
        logic [15:0]  be;
        logic [127:0] mask;
        logic         hit_now;
        int           idx;
        int           lane;
        if (!arst_n) begin
            pend     <= 1'b0;
            pend_age <= 0;
            mem_cnt  <= 0;
            sh_valid = '0;
        end else begin
            if (pend) pend_age <= pend_age + 1;
            if (mem_req_valid) mem_cnt <= mem_cnt + 1;
            if (core_rsp_valid) pend <= 1'b0;
            if (core_req_valid && !busy) begin
                a       = core_req.addr;
                idx     = int'(a[4 +: INDEX_BITS]);
                lane    = int'(a[3:2]);
                hit_now = sh_valid[idx] && (sh_line[idx] == a[31:4]);
                for (int b = 0; b < 16; b++) begin
                    be[b] = (core_req.op == cache_core_pkg::OP_READ)
                         || ((b / 4 == lane) && core_req.byteen[b % 4]);
                    mask[b*8 +: 8] = {8{be[b]}};
                end
                pend      <= 1'b1;
                pend_age  <= 0;
                mem_cnt   <= 0;
                pend_addr <= a;
                pend_read <= core_req.op == cache_core_pkg::OP_READ;
                pend_hit  <= hit_now;
                exp_data  <= shadow_word(a);
                exp_be    <= be;
                exp_mask  <= mask;
                exp_line  <= (core_req.op == cache_core_pkg::OP_READ) ? '0
                           : 128'(core_req.data) << (lane * 32);
                if (core_req.op == cache_core_pkg::OP_WRITE) begin
                    for (int b = 0; b < 4; b++) begin
                        if (core_req.byteen[b]) begin
                            shadow_mem[{a[31:2], 2'b00} + b] = core_req.data[b*8 +: 8];
                        end
                    end
                end else if (!hit_now) begin
                    sh_valid[idx] = 1'b1; // Read miss fills the line.
                    sh_line[idx]  = a[31:4];
                end
            end
        end
    end

    ////////////////////
    // Reporting.

    task automatic report_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        err_count++;
        $display("ERR %s got %0h exp %0h", name, got, exp);
    endtask

    task automatic report_fail(input string what);
        err_count++;
        $display("Check failed: %s", what);
    endtask

    task automatic finish_run();
        $display("Checks failed: %0d, timeouts: %0d", err_count, timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        timeouts++;
        $display("Timeout: %s", what);
        finish_run();
    endtask

    ////////////////////
    // Checks.

    reset_idle: assert property (@(posedge clk)
        $rose(arst_n) |-> !busy && !core_rsp_valid && !mem_req_valid)
        else report_fail("busy, core_rsp_valid or mem_req_valid high after reset");

    rsp_data: assert property (@(posedge clk) disable iff (!arst_n)
        core_rsp_valid && pend_read |-> core_rsp.data == exp_data)
        else report_value("core_rsp.data", $sampled(core_rsp.data), $sampled(exp_data));

    hit_latency: assert property (@(posedge clk) disable iff (!arst_n)
        core_rsp_valid && pend_read && pend_hit |-> pend_age == 1)
        else report_fail("read hit not answered one cycle after the accept edge");

    mem_count: assert property (@(posedge clk) disable iff (!arst_n)
        core_rsp_valid |-> mem_cnt == ((pend_read && pend_hit) ? 0 : 1))
        else report_value("mem_req_valid count", $sampled(mem_cnt),
                          $sampled(pend_read && pend_hit) ? 0 : 1);

    mem_op: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid |-> mem_req.op == (pend_read ? cache_mem_pkg::MEM_READ
                                                   : cache_mem_pkg::MEM_WRITE))
        else report_value("mem_req.op", $sampled(mem_req.op), !$sampled(pend_read));

    mem_addr: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid |-> mem_req.line_addr == pend_addr[31:4])
        else report_value("mem_req.line_addr", $sampled(mem_req.line_addr),
                          $sampled(pend_addr[31:4]));

    mem_be: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid |-> mem_req.byteen == exp_be)
        else report_value("mem_req.byteen", $sampled(mem_req.byteen), $sampled(exp_be));

    mem_data: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req_valid |-> (mem_req.data & exp_mask) == (exp_line & exp_mask))
        else report_value("mem_req.data", $sampled(mem_req.data & exp_mask),
                          $sampled(exp_line & exp_mask));

    busy_pending: assert property (@(posedge clk) disable iff (!arst_n)
        pend && !core_rsp_valid |-> busy)
        else report_fail("busy low while a response is pending");

    rsp_owner: assert property (@(posedge clk) disable iff (!arst_n)
        core_rsp_valid |-> pend)
        else report_fail("response without an accepted request");

    ////////////////////
    // Stimulus.

    task automatic request(input cache_core_pkg::core_op_e op, input logic [31:0] addr,
                           input logic [3:0] byteen, input logic [31:0] data);
        int waited;
        waited = 0;
        while (busy && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (busy) abort_on_timeout("bank stayed busy before a new request");
        @(posedge clk);
        core_req_valid <= 1'b1;
        core_req       <= '{op: op, addr: addr, byteen: byteen, data: data};
        @(posedge clk);
        core_req_valid <= 1'b0; // Accepted at this edge.
        waited = 0;
        @(negedge clk);
        while (!core_rsp_valid && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!core_rsp_valid) abort_on_timeout("no response to a request");
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] addr;
        clk            = 1'b0;
        arst_n         = 1'b0;
        core_req_valid = 1'b0;
        core_req       = '0;
        err_count      = 0;
        timeouts       = 0;
        rnd            = 32'd37;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        // Miss, hit on the same line, partial write hit, merged read back.
        request(cache_core_pkg::OP_READ, 32'h0000_1234, 4'h0, 32'h0);
        request(cache_core_pkg::OP_READ, 32'h0000_1238, 4'h0, 32'h0);
        request(cache_core_pkg::OP_WRITE, 32'h0000_123C, 4'b0110, 32'hDEAD_BEEF);
        request(cache_core_pkg::OP_READ, 32'h0000_123C, 4'h0, 32'h0);

        // Write miss leaves the line out of the cache.
        request(cache_core_pkg::OP_WRITE, 32'h0000_5678, 4'hF, 32'h1357_9BDF);
        request(cache_core_pkg::OP_READ, 32'h0000_5678, 4'h0, 32'h0);

        // Same index, two tags.
        for (int i = 0; i < 6; i++) begin
            request(cache_core_pkg::OP_READ, 32'h0000_2040 + 32'(i % 2) * LINES * 16,
                    4'h0, 32'h0);
        end

        // Random mix over four indexes and four tags.
        for (int i = 0; i < 200; i++) begin
            rnd  = xorshift(rnd);
            r    = rnd;
            addr = 32'h0008_0000 | (32'(r[4:3]) << 10) | (32'(r[2:1]) << 4)
                 | (32'(r[6:5]) << 2);
            rnd  = xorshift(rnd);
            request(cache_core_pkg::core_op_e'(r[0]), addr, r[10:7], rnd);
        end

        repeat (2) @(posedge clk);
        finish_run();
    end

endmodule

//--- project.f
src/cache_core_pkg.sv
src/cache_mem_pkg.sv
src/tag_access.sv
src/data_access.sv
src/word_lane.sv
src/mem_port.sv
src/bank_ctrl.sv
src/cache_bank_top.sv
sim/tb_mem_model.sv
sim/tb_cache_bank.sv
